/* dv/exec_unit_checker.sv */
`default_nettype none
`timescale 1ns/1ns

module exec_unit_checker (
    input logic                     clk,
    input logic                     rst_n,
    input exec_ctrl_pkg::dec_ctrl_t ctrl,
    input logic                     wb_valid,
    input logic                     redirect_valid
);
    logic accepted;   // instruction that must write rd
    logic last_jal;

    assign accepted = ctrl.valid && ctrl.rd_we && (ctrl.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_jal <= 1'b0;
        end else begin
            last_jal <= ctrl.valid && ctrl.is_jal;
        end
    end

    wb_follows_accept: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |=> wb_valid)
        else $error("wb_valid missing one cycle after an accepted instruction");

    wb_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
        !accepted |=> !wb_valid)
        else $error("wb_valid raised without an accepted instruction");

    redirect_only_jal_writes: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> (!wb_valid || last_jal))
        else $error("redirect with writeback from an instruction other than jal");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!wb_valid && !redirect_valid))
        else $error("writeback or redirect active during reset");

endmodule

bind exec_unit_top exec_unit_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .wb_valid      (wb_valid),
    .redirect_valid(redirect_valid)
);

`default_nettype wire

/* dv/exec_unit_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module exec_unit_tb;
    import rv_isa_pkg::*;

    localparam int TIMEOUT = 20;   // cycles to wait for a writeback or redirect

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] reg1_rdata;
    logic [XLEN-1:0] reg2_rdata;
    logic            bubble;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [XLEN-1:0] wb_data;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;

    logic [31:0]     lfsr;
    logic [XLEN-1:0] csr_m [5];   // model copy in mstatus, mie, mtvec, mepc, mcause order
    logic            timed_out;
    int              errors;
    int              tests;

    exec_unit_top #(.RESET_MTVEC(64'h100)) DUT (.*);

    always #4 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [XLEN-1:0] rand_bits(input int n);
        logic [XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v    = {v[XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [2:0] csr_index(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS: return 3'd0;
            CSR_MIE:     return 3'd1;
            CSR_MTVEC:   return 3'd2;
            CSR_MEPC:    return 3'd3;
            CSR_MCAUSE:  return 3'd4;
            default:     return 3'd7;   // not a csr we hold
        endcase
    endfunction

    function automatic logic [11:0] csr_addr_of(input int i);
        case (i)
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MTVEC;
            3:       return CSR_MEPC;
            default: return CSR_MCAUSE;
        endcase
    endfunction

    // k picks add, sub, and, or, xor; in the imm form k == 1 gives auipc
    function automatic logic [31:0] arith_word(input int k, input logic imm_form,
                                               input logic [4:0] rd);
        logic [2:0] f3;
        case (k)
            0, 1:    f3 = F3_ADD;
            2:       f3 = F3_AND;
            3:       f3 = F3_OR;
            default: f3 = F3_XOR;
        endcase
        if (imm_form && k == 1) return {20'(rand_bits(20)), rd, OPC_AUIPC};
        if (imm_form) return {12'(rand_bits(12)), 5'd1, f3, rd, OPC_OP_IMM};
        return {(k == 1) ? F7_ALT : F7_BASE, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] csr_word(input logic [11:0] addr, input logic [2:0] f3,
                                             input logic [4:0] src, input logic [4:0] rd);
        return {addr, src, f3, rd, OPC_SYSTEM};
    endfunction

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            $display("[FAIL] t=%0t %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %s %s", name,
                 (errors == errs_before && !timed_out) ? "passed" : "failed");
    endtask

    // drives one instruction at edge+1 and checks the response one edge later
    task automatic run_instr(input logic [31:0] w, input logic [XLEN-1:0] p,
                             input logic [XLEN-1:0] r1, input logic [XLEN-1:0] r2,
                             input logic bub);
        logic [2:0]      f3;
        logic [4:0]      rd;
        logic [2:0]      ci;
        logic            known;
        logic [XLEN-1:0] i_imm;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] target;
        logic            exp_wb;
        logic            exp_redir;
        int              cycles;
        if (timed_out) return;
        f3        = w[14:12];
        rd        = w[11:7];
        ci        = csr_index(w[31:20]);
        known     = (ci != 3'd7);
        i_imm     = {{52{w[31]}}, w[31:20]};
        data      = '0;
        target    = '0;
        exp_wb    = 1'b0;
        exp_redir = 1'b0;
        if (!bub) begin
            exp_wb = 1'b1;
            case (w[6:0])
                OPC_OP: begin
                    case (f3)
                        F3_ADD:  data = w[30] ? r1 - r2 : r1 + r2;
                        F3_XOR:  data = r1 ^ r2;
                        F3_OR:   data = r1 | r2;
                        default: data = r1 & r2;
                    endcase
                end
                OPC_OP_IMM: begin
                    case (f3)
                        F3_ADD:  data = r1 + i_imm;
                        F3_XOR:  data = r1 ^ i_imm;
                        F3_OR:   data = r1 | i_imm;
                        default: data = r1 & i_imm;
                    endcase
                end
                OPC_AUIPC: data = p + {{32{w[31]}}, w[31:12], 12'b0};
                OPC_JAL: begin
                    data      = p + 64'd4;
                    exp_redir = 1'b1;
                    target    = p + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: begin
                    if (w == ECALL_WORD) begin
                        exp_wb    = 1'b0;
                        exp_redir = 1'b1;
                        target    = csr_m[2];   // mtvec before the update
                    end else begin
                        data = known ? csr_m[ci] : r2;
                    end
                end
            endcase
            exp_wb = exp_wb && (rd != 5'd0);
        end
        instr_valid = 1'b1;
        instr       = w;
        pc          = p;
        reg1_rdata  = r1;
        reg2_rdata  = r2;
        bubble      = bub;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        bubble      = 1'b0;
        cycles      = 1;
        while ((exp_wb || exp_redir) && !(wb_valid || redirect_valid) && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            $display("timeout: no writeback or redirect within %0d cycles for %h", TIMEOUT, w);
            timed_out = 1'b1;
            return;
        end
        check(cycles == 1, $sformatf("response after %0d cycles for %h", cycles, w));
        check(wb_valid == exp_wb,
              $sformatf("wb_valid %0b expected %0b for %h", wb_valid, exp_wb, w));
        if (exp_wb) begin
            check(wb_rd == rd, $sformatf("wb_rd %0d expected %0d for %h", wb_rd, rd, w));
            check(wb_data == data,
                  $sformatf("wb_data %h expected %h for %h", wb_data, data, w));
        end
        check(redirect_valid == exp_redir,
              $sformatf("redirect_valid %0b expected %0b for %h", redirect_valid, exp_redir, w));
        if (exp_redir) begin
            check(redirect_pc == target,
                  $sformatf("redirect_pc %h expected %h for %h", redirect_pc, target, w));
        end
        if (!bub && w[6:0] == OPC_SYSTEM && known && f3 == F3_CSRRS) csr_m[ci] |= r1;
        if (!bub && w[6:0] == OPC_SYSTEM && known && f3 == F3_CSRRSI) begin
            csr_m[ci] |= {59'b0, w[19:15]};
        end
        if (!bub && w == ECALL_WORD) begin
            csr_m[3] = p;
            csr_m[4] = CAUSE_ECALL_M;
        end
    endtask

    // presents an instruction with instr_valid low, nothing may come back
    task automatic idle_instr(input logic [31:0] w, input logic [XLEN-1:0] p,
                              input logic [XLEN-1:0] r1);
        if (timed_out) return;
        instr_valid = 1'b0;
        instr       = w;
        pc          = p;
        reg1_rdata  = r1;
        reg2_rdata  = '0;
        bubble      = 1'b0;
        @(posedge clk);
        #1;
        check(!wb_valid, $sformatf("wb_valid raised without instr_valid for %h", w));
        check(!redirect_valid,
              $sformatf("redirect_valid raised without instr_valid for %h", w));
    endtask

    initial begin
        int              errs_at_start;
        int              k;
        logic [XLEN-1:0] p;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        reg1_rdata  = '0;
        reg2_rdata  = '0;
        bubble      = 1'b0;
        lfsr        = 32'h227f68b2;
        timed_out   = 1'b0;
        errors      = 0;
        tests       = 0;
        csr_m       = '{64'h0, 64'h0, 64'h100, 64'h0, 64'h0};
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;

        errs_at_start = errors;
        for (int i = 0; i < 12; i++) begin
            k = int'(rand_bits(3)) % 5;
            run_instr(arith_word(k, 1'b0, (i == 0) ? 5'd0 : 5'(rand_bits(5))),
                      rand_bits(40) << 2, rand_bits(64), rand_bits(64), 1'b0);
        end
        report_test("r-type", errs_at_start);

        errs_at_start = errors;
        for (int i = 0; i < 12; i++) begin
            k = int'(rand_bits(3)) % 5;
            run_instr(arith_word(k, 1'b1, 5'(rand_bits(5))), rand_bits(40) << 2,
                      rand_bits(64), rand_bits(64), 1'b0);
        end
        report_test("immediate", errs_at_start);

        errs_at_start = errors;
        for (int i = 0; i < 6; i++) begin
            run_instr({20'(rand_bits(20)), 5'(rand_bits(5)), OPC_JAL}, rand_bits(40) << 2,
                      '0, '0, 1'b0);
        end
        report_test("jal", errs_at_start);

        // runs before the csr test so the first ecall sees the reset mtvec
        errs_at_start = errors;
        p = rand_bits(40) << 2;
        run_instr(ECALL_WORD, p, '0, '0, 1'b0);
        run_instr(csr_word(CSR_MTVEC, F3_CSRRS, 5'd1, 5'd3), p + 64'd4, 64'h200, '0, 1'b0);
        run_instr(ECALL_WORD, p + 64'd8, '0, '0, 1'b0);
        run_instr(csr_word(CSR_MEPC, F3_CSRRS, 5'd0, 5'd4), p + 64'd12, '0, '0, 1'b0);
        run_instr(csr_word(CSR_MCAUSE, F3_CSRRS, 5'd0, 5'd5), p + 64'd16, '0, '0, 1'b0);
        report_test("ecall", errs_at_start);

        errs_at_start = errors;
        for (int i = 0; i < 5; i++) begin
            run_instr(csr_word(csr_addr_of(i), F3_CSRRS, 5'd1, 5'(i + 6)), p,
                      rand_bits(64), rand_bits(64), 1'b0);
            run_instr(csr_word(csr_addr_of(i), F3_CSRRSI, 5'(rand_bits(5)), 5'(i + 6)), p,
                      rand_bits(64), rand_bits(64), 1'b0);
            run_instr(csr_word(csr_addr_of(i), F3_CSRRS, 5'd0, 5'd12), p, '0, '0, 1'b0);
        end
        run_instr(csr_word(12'h7c0, F3_CSRRS, 5'd1, 5'd13), p, rand_bits(64),
                  rand_bits(64), 1'b0);   // unknown address
        run_instr(csr_word(12'h7c0, F3_CSRRSI, 5'd9, 5'd14), p, rand_bits(64),
                  rand_bits(64), 1'b0);
        report_test("csr", errs_at_start);

        errs_at_start = errors;
        run_instr(csr_word(CSR_MSTATUS, F3_CSRRS, 5'd1, 5'd8), p, '1, '0, 1'b1);
        run_instr({20'(rand_bits(20)), 5'd9, OPC_JAL}, p, '0, '0, 1'b1);
        run_instr(ECALL_WORD, p + 64'd4, '0, '0, 1'b1);
        idle_instr(csr_word(CSR_MSTATUS, F3_CSRRS, 5'd1, 5'd8), p, '1);
        idle_instr({20'(rand_bits(20)), 5'd9, OPC_JAL}, p, '0);
        idle_instr(ECALL_WORD, p + 64'd4, '0);
        for (int i = 0; i < 6; i++) begin
            k = int'(rand_bits(3)) % 5;
            run_instr(arith_word(k, 1'b0, 5'(rand_bits(5))), p, rand_bits(64),
                      rand_bits(64), 1'(rand_bits(1)));
        end
        run_instr(csr_word(CSR_MSTATUS, F3_CSRRS, 5'd0, 5'd8), p, '0, '0, 1'b0);
        run_instr(csr_word(CSR_MEPC, F3_CSRRS, 5'd0, 5'd10), p, '0, '0, 1'b0);
        report_test("bubble", errs_at_start);

        $display("tests: %0d, errors: %0d, timeout: %0b", tests, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/rv_isa_pkg.sv
hw/exec_ctrl_pkg.sv
hw/instr_decoder.sv
hw/alu_operand_mux.sv
hw/csr_file.sv
hw/alu.sv
hw/writeback_stage.sv
hw/exec_unit_top.sv
dv/exec_unit_checker.sv
dv/exec_unit_tb.sv

/* hw/alu.sv */
`default_nettype none
`timescale 1ns/1ns

module alu (
    input  exec_ctrl_pkg::alu_op_e        alu_op,
    input  logic [rv_isa_pkg::XLEN-1:0]   src1,
    input  logic [rv_isa_pkg::XLEN-1:0]   src2,
    output exec_ctrl_pkg::exec_res_t      res
);
    import exec_ctrl_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ADD: res.alu_result = src1 + src2;
            ALU_SUB: res.alu_result = src1 - src2;
            ALU_AND: res.alu_result = src1 & src2;
            ALU_OR:  res.alu_result = src1 | src2;  // also csr set
            ALU_XOR: res.alu_result = src1 ^ src2;
            default: res.alu_result = '0;
        endcase
        res.src2 = src2;   // old csr value rides along
    end

endmodule

`default_nettype wire

/* hw/alu_operand_mux.sv */
`default_nettype none
`timescale 1ns/1ns

module alu_operand_mux (
    input  exec_ctrl_pkg::dec_ctrl_t      ctrl,
    input  logic [rv_isa_pkg::XLEN-1:0]   reg1_rdata,
    input  logic [rv_isa_pkg::XLEN-1:0]   reg2_rdata,
    input  exec_ctrl_pkg::csr_view_t      csrs,
    output logic [rv_isa_pkg::XLEN-1:0]   src1,
    output logic [rv_isa_pkg::XLEN-1:0]   src2
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    logic            csr_hit;   // csr address is one we hold
    logic [XLEN-1:0] csr_rdata;

    always_comb begin
        csr_hit = 1'b1;
        case (ctrl.csr_addr)
            CSR_MSTATUS: csr_rdata = csrs.mstatus;
            CSR_MIE:     csr_rdata = csrs.mie;
            CSR_MTVEC:   csr_rdata = csrs.mtvec;
            CSR_MEPC:    csr_rdata = csrs.mepc;
            CSR_MCAUSE:  csr_rdata = csrs.mcause;
            default: begin
                csr_rdata = '0;
                csr_hit   = 1'b0;
            end
        endcase
    end

    always_comb begin
        src1 = reg1_rdata;    // default reg1
        src2 = reg2_rdata;    // default reg2
        if (ctrl.bubble) begin
            src2 = '0;        // hazard kills operand 2
        end else begin
            case (ctrl.src_sel)
                SRC_REG:     src2 = reg2_rdata;
                SRC_IMM:     src2 = ctrl.imm;
                SRC_FOUR_PC: begin
                    src1 = XLEN'(4);
                    src2 = ctrl.pc;
                end
                SRC_IMM_PC: begin
                    src1 = ctrl.imm;
                    src2 = ctrl.pc;
                end
                SRC_CSRRS: begin
                    if (csr_hit) src2 = csr_rdata;
                end
                SRC_CSRRSI: begin
                    if (csr_hit) begin
                        src1 = ctrl.imm;
                        src2 = csr_rdata;
                    end
                end
                SRC_ECALL: begin
                    src1 = ctrl.pc;
                    src2 = ctrl.pc;
                end
                default: begin
                    src1 = ctrl.pc;
                    src2 = ctrl.pc;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/csr_file.sv */
`default_nettype none
`timescale 1ns/1ns

module csr_file #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_MTVEC = 64'h100
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  exec_ctrl_pkg::dec_ctrl_t   ctrl,
    input  exec_ctrl_pkg::exec_res_t   res,
    output exec_ctrl_pkg::csr_view_t   csrs
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    logic csr_set;

    // csrrs and csrrsi both or into the csr
    assign csr_set = ctrl.valid && (ctrl.src_sel == SRC_CSRRS || ctrl.src_sel == SRC_CSRRSI);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csrs.mstatus <= '0;
            csrs.mie     <= '0;
            csrs.mtvec   <= RESET_MTVEC;
            csrs.mepc    <= '0;
            csrs.mcause  <= '0;
        end else if (csr_set) begin
            case (ctrl.csr_addr)
                CSR_MSTATUS: csrs.mstatus <= res.alu_result;
                CSR_MIE:     csrs.mie     <= res.alu_result;
                CSR_MTVEC:   csrs.mtvec   <= res.alu_result;
                CSR_MEPC:    csrs.mepc    <= res.alu_result;
                CSR_MCAUSE:  csrs.mcause  <= res.alu_result;
                default: ;   // unknown address writes nothing
            endcase
        end else if (ctrl.valid && ctrl.is_ecall) begin
            csrs.mepc   <= ctrl.pc;         // trap return address
            csrs.mcause <= CAUSE_ECALL_M;
        end
    end

endmodule

`default_nettype wire

/* hw/exec_ctrl_pkg.sv */
`default_nettype none

package exec_ctrl_pkg;

    // where the two alu operands come from
    typedef enum logic [2:0] {
        SRC_REG     = 3'd0,
        SRC_IMM     = 3'd1,
        SRC_FOUR_PC = 3'd2,
        SRC_IMM_PC  = 3'd3,
        SRC_CSRRS   = 3'd4,
        SRC_CSRRSI  = 3'd5,
        SRC_ECALL   = 3'd6
    } alu_src_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic                          valid;
        logic                          bubble;
        alu_src_e                      src_sel;
        alu_op_e                       alu_op;
        logic [4:0]                    rd;
        logic                          rd_we;
        logic [11:0]                   csr_addr;
        logic [rv_isa_pkg::XLEN-1:0]   imm;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        logic                          is_jal;
        logic                          is_ecall;
    } dec_ctrl_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0] mstatus;
        logic [rv_isa_pkg::XLEN-1:0] mie;
        logic [rv_isa_pkg::XLEN-1:0] mtvec;
        logic [rv_isa_pkg::XLEN-1:0] mepc;
        logic [rv_isa_pkg::XLEN-1:0] mcause;
    } csr_view_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0] alu_result;
        logic [rv_isa_pkg::XLEN-1:0] src2; // old csr value on csr reads
    } exec_res_t;

endpackage

`default_nettype wire

/* hw/exec_unit_top.sv */
`default_nettype none
`timescale 1ns/1ns

module exec_unit_top #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_MTVEC = 64'h100
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    input  logic [rv_isa_pkg::XLEN-1:0]   pc,
    input  logic [rv_isa_pkg::XLEN-1:0]   reg1_rdata,
    input  logic [rv_isa_pkg::XLEN-1:0]   reg2_rdata,
    input  logic                          bubble,
    output logic                          wb_valid,
    output logic [4:0]                    wb_rd,
    output logic [rv_isa_pkg::XLEN-1:0]   wb_data,
    output logic                          redirect_valid,
    output logic [rv_isa_pkg::XLEN-1:0]   redirect_pc
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    dec_ctrl_t       ctrl;
    csr_view_t       csrs;
    exec_res_t       res;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;

    instr_decoder u_dec (
        .instr_valid(instr_valid),
        .instr      (instr),
        .pc         (pc),
        .bubble     (bubble),
        .ctrl       (ctrl)
    );

    alu_operand_mux u_mux (
        .ctrl      (ctrl),
        .reg1_rdata(reg1_rdata),
        .reg2_rdata(reg2_rdata),
        .csrs      (csrs),
        .src1      (src1),
        .src2      (src2)
    );

    csr_file #(.RESET_MTVEC(RESET_MTVEC)) u_csr (
        .clk  (clk),
        .rst_n(rst_n),
        .ctrl (ctrl),
        .res  (res),
        .csrs (csrs)
    );

    alu u_alu (
        .alu_op(ctrl.alu_op),
        .src1  (src1),
        .src2  (src2),
        .res   (res)
    );

    writeback_stage u_wb (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .res           (res),
        .csrs          (csrs),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`default_nettype none
`timescale 1ns/1ns

module instr_decoder (
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    input  logic [rv_isa_pkg::XLEN-1:0]   pc,
    input  logic                          bubble,
    output exec_ctrl_pkg::dec_ctrl_t      ctrl
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    f3_op;      // shared by reg and imm forms
    logic       f3_ok;
    logic       supported;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD:  f3_op = ALU_ADD;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;      // shifts and compares not here
            end
        endcase
    end

    always_comb begin
        ctrl          = '0;
        ctrl.src_sel  = SRC_REG;
        ctrl.alu_op   = ALU_ADD;
        ctrl.rd       = instr[11:7];
        ctrl.csr_addr = instr[31:20];
        ctrl.pc       = pc;
        ctrl.bubble   = bubble;
        supported     = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.src_sel = SRC_REG;
                if (funct7 == F7_BASE) begin
                    ctrl.alu_op = f3_op;
                    supported   = f3_ok;
                end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
                    ctrl.alu_op = ALU_SUB;
                    supported   = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                ctrl.src_sel = SRC_IMM;
                ctrl.alu_op  = f3_op;
                ctrl.imm     = {{(XLEN-12){instr[31]}}, instr[31:20]};
                supported    = f3_ok;
            end
            OPC_AUIPC: begin
                ctrl.src_sel = SRC_IMM_PC;
                ctrl.imm     = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};
                supported    = 1'b1;
            end
            OPC_JAL: begin
                ctrl.src_sel = SRC_FOUR_PC; // rd gets pc + 4
                ctrl.imm     = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12],
                                instr[20], instr[30:21], 1'b0};
                ctrl.is_jal  = 1'b1;
                supported    = 1'b1;
            end
            OPC_SYSTEM: begin
                ctrl.alu_op = ALU_OR;
                if (funct3 == F3_CSRRS) begin
                    ctrl.src_sel = SRC_CSRRS;
                    supported    = 1'b1;
                end else if (funct3 == F3_CSRRSI) begin
                    ctrl.src_sel = SRC_CSRRSI;
                    ctrl.imm     = {{(XLEN-5){1'b0}}, instr[19:15]}; // zero-extended uimm
                    supported    = 1'b1;
                end else if (funct3 == F3_PRIV && instr == ECALL_WORD) begin
                    ctrl.src_sel  = SRC_ECALL;
                    ctrl.is_ecall = 1'b1;
                    supported     = 1'b1;
                end
            end
            default: supported = 1'b0;
        endcase
        ctrl.rd_we = supported & ~ctrl.is_ecall;
        ctrl.valid = instr_valid & ~bubble & supported;
    end

endmodule

`default_nettype wire

/* hw/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    parameter int XLEN = 64;

    // major opcodes in bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [2:0] F3_ADD    = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_PRIV   = 3'b000; // ecall lives here
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRSI = 3'b110;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20; // sub

    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

    // machine mode csrs
    localparam logic [11:0] CSR_MSTATUS = 12'd768;
    localparam logic [11:0] CSR_MIE     = 12'd772;
    localparam logic [11:0] CSR_MTVEC   = 12'd773;
    localparam logic [11:0] CSR_MEPC    = 12'd833;
    localparam logic [11:0] CSR_MCAUSE  = 12'd834;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

endpackage

`default_nettype wire

/* hw/writeback_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module writeback_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  exec_ctrl_pkg::dec_ctrl_t      ctrl,
    input  exec_ctrl_pkg::exec_res_t      res,
    input  exec_ctrl_pkg::csr_view_t      csrs,
    output logic                          wb_valid,
    output logic [4:0]                    wb_rd,
    output logic [rv_isa_pkg::XLEN-1:0]   wb_data,
    output logic                          redirect_valid,
    output logic [rv_isa_pkg::XLEN-1:0]   redirect_pc
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    logic            csr_read;
    logic            rd_write;
    logic [XLEN-1:0] jal_target;

    assign csr_read   = (ctrl.src_sel == SRC_CSRRS) || (ctrl.src_sel == SRC_CSRRSI);
    assign rd_write   = ctrl.valid && ctrl.rd_we && (ctrl.rd != 5'd0); // x0 never written
    assign jal_target = ctrl.pc + ctrl.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= rd_write;
            redirect_valid <= ctrl.valid && (ctrl.is_jal || ctrl.is_ecall);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= ctrl.rd;
        wb_data     <= csr_read ? res.src2 : res.alu_result;
        redirect_pc <= ctrl.is_jal ? jal_target : csrs.mtvec; // mtvec before this edge
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module exec_unit_tb -Mdir obj_dir -f files.f

./obj_dir/Vexec_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
